// File: source/dcache_pkg.sv
package dcache_pkg;

	// geometry
	localparam int ADDR_W = 32;
	localparam int WORD_W = 64;
	localparam int WAYS = 2;
	localparam int SETS = 64;
	localparam int WORDS_PER_LINE = 4;
	localparam int OFFSET_W = 2;
	localparam int INDEX_W = 6;
	localparam int BYTE_OFF_W = 3;
	localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W - BYTE_OFF_W;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [WORD_W/8-1:0] wmask_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [OFFSET_W-1:0] woff_t;
	typedef logic [$clog2(WAYS)-1:0] way_t;

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		WBACK,
		REFILL,
		RELOOK
	} ctrl_state_e;

	typedef struct packed {
		addr_t addr;
		logic write;
		word_t wdata;
		wmask_t wmask;
	} cpu_req_t;

	// one memory beat, word aligned
	typedef struct packed {
		addr_t addr;
		logic write;
		word_t wdata;
	} mem_req_t;

	// address field split: tag | index | word offset | byte
	function automatic tag_t addr_tag(addr_t a);
		return a[ADDR_W-1 -: TAG_W];
	endfunction

	function automatic index_t addr_index(addr_t a);
		return a[BYTE_OFF_W+OFFSET_W +: INDEX_W];
	endfunction

	function automatic woff_t addr_woff(addr_t a);
		return a[BYTE_OFF_W +: OFFSET_W];
	endfunction

endpackage

// File: source/dcache_ctrl.sv
`timescale 1ns/1ns

module dcache_ctrl (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  cpu_valid,
	input  dcache_pkg::cpu_req_t  cpu_req,
	output logic                  cpu_ready,
	output dcache_pkg::index_t    lk_index,
	output dcache_pkg::tag_t      lk_tag,
	input  logic                  hit,
	input  dcache_pkg::way_t      hit_way,
	input  dcache_pkg::way_t      victim_way,
	input  logic                  victim_dirty,
	input  dcache_pkg::tag_t      victim_tag,
	output logic                  install,
	output dcache_pkg::way_t      install_way,
	output logic                  mark_dirty,
	output logic                  wr_en,
	output dcache_pkg::way_t      wr_way,
	output dcache_pkg::woff_t     wr_off,
	output dcache_pkg::word_t     wr_data,
	output dcache_pkg::wmask_t    wr_mask,
	output dcache_pkg::way_t      rd_way,
	output dcache_pkg::woff_t     rd_off,
	output logic                  start_wb,
	output logic                  start_fill,
	output dcache_pkg::way_t      xfer_way,
	output dcache_pkg::tag_t      xfer_tag,
	input  logic                  xfer_done,
	output logic                  init_busy
);

	dcache_pkg::ctrl_state_e state;
	dcache_pkg::cpu_req_t req_q;
	dcache_pkg::way_t vway_q;
	dcache_pkg::tag_t vtag_q;
	dcache_pkg::index_t init_cnt;
	logic init_q;
	logic ready_q;
	logic start_wb_q;
	logic start_fill_q;
	logic accept;
	logic lookup_st;

	assign accept = (state == dcache_pkg::IDLE) && cpu_valid && !init_q;
	assign lookup_st = (state == dcache_pkg::LOOKUP) || (state == dcache_pkg::RELOOK);

	// array address: sweep counter, then the new request, else the saved one
	always_comb begin
		if (init_q) begin
			lk_index = init_cnt;
			lk_tag = dcache_pkg::addr_tag(req_q.addr);
		end else if (accept) begin
			lk_index = dcache_pkg::addr_index(cpu_req.addr);
			lk_tag = dcache_pkg::addr_tag(cpu_req.addr);
		end else begin
			lk_index = dcache_pkg::addr_index(req_q.addr);
			lk_tag = dcache_pkg::addr_tag(req_q.addr);
		end
	end

	// lookup takes two cycles: tag compare, then the word is out
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= dcache_pkg::IDLE;
			ready_q <= 1'b0;
			start_wb_q <= 1'b0;
			start_fill_q <= 1'b0;
			init_q <= 1'b1;
			init_cnt <= '0;
		end else begin
			ready_q <= 1'b0;
			start_wb_q <= 1'b0;
			start_fill_q <= 1'b0;
			if (init_q) begin
				init_cnt <= init_cnt + 1'b1;
				if (init_cnt == dcache_pkg::index_t'(dcache_pkg::SETS - 1)) begin
					init_q <= 1'b0;
				end
			end
			case (state)
				dcache_pkg::IDLE: begin
					if (accept) begin
						state <= dcache_pkg::LOOKUP;
					end
				end
				dcache_pkg::LOOKUP, dcache_pkg::RELOOK: begin
					if (ready_q) begin
						state <= dcache_pkg::IDLE;
					end else if (hit) begin
						ready_q <= 1'b1;
					end else if (victim_dirty) begin
						state <= dcache_pkg::WBACK;
						start_wb_q <= 1'b1;
					end else begin
						state <= dcache_pkg::REFILL;
						start_fill_q <= 1'b1;
					end
				end
				dcache_pkg::WBACK: begin
					if (xfer_done) begin
						state <= dcache_pkg::REFILL;
						start_fill_q <= 1'b1;
					end
				end
				dcache_pkg::REFILL: begin
					if (xfer_done) begin
						state <= dcache_pkg::RELOOK;
					end
				end
				default: begin
					state <= dcache_pkg::IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_q <= cpu_req;
		end
		// victim captured on the miss cycle
		if (lookup_st && !ready_q && !hit) begin
			vway_q <= victim_way;
			vtag_q <= victim_tag;
		end
	end

	assign cpu_ready = ready_q;
	assign init_busy = init_q;

	// store data and set dirty together with the ready pulse
	assign wr_en = ready_q && req_q.write;
	assign mark_dirty = ready_q && req_q.write;
	assign wr_way = hit_way;
	assign wr_off = dcache_pkg::addr_woff(req_q.addr);
	assign wr_data = req_q.wdata;
	assign wr_mask = req_q.wmask;
	assign rd_way = hit_way;
	assign rd_off = dcache_pkg::addr_woff(req_q.addr);

	assign install = (state == dcache_pkg::REFILL) && xfer_done;
	assign install_way = vway_q;

	assign start_wb = start_wb_q;
	assign start_fill = start_fill_q;
	assign xfer_way = vway_q;
	// write-back goes to the old owner's address
	assign xfer_tag = (state == dcache_pkg::WBACK) ? vtag_q : dcache_pkg::addr_tag(req_q.addr);

	a_ready_on_hit: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_ready |-> (lookup_st && hit));

	a_start_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(start_wb && start_fill));

endmodule

// File: source/dcache_tag_store.sv
`timescale 1ns/1ns

module dcache_tag_store (
	input  logic               clk,
	input  logic               rst_n,
	input  dcache_pkg::index_t index,
	input  dcache_pkg::tag_t   tag,
	input  logic               init_busy,
	input  logic               install,
	input  dcache_pkg::way_t   install_way,
	input  logic               mark_dirty,
	output logic               hit,
	output dcache_pkg::way_t   hit_way,
	output dcache_pkg::way_t   victim_way,
	output logic               victim_dirty,
	output dcache_pkg::tag_t   victim_tag
);

	logic valid [dcache_pkg::WAYS][dcache_pkg::SETS];
	logic dirty [dcache_pkg::WAYS][dcache_pkg::SETS];
	dcache_pkg::tag_t tags [dcache_pkg::WAYS][dcache_pkg::SETS];
	// way to evict next
	logic lru [dcache_pkg::SETS];

	dcache_pkg::index_t index_q;
	dcache_pkg::tag_t tag_q;
	logic [dcache_pkg::WAYS-1:0] rd_valid;
	logic [dcache_pkg::WAYS-1:0] rd_dirty;
	dcache_pkg::tag_t rd_tag [dcache_pkg::WAYS];
	logic rd_lru;
	logic [dcache_pkg::WAYS-1:0] hit_vec;

	always_ff @(posedge clk) begin
		if (init_busy) begin
			for (int w = 0; w < dcache_pkg::WAYS; w++) begin
				valid[w][index] <= 1'b0;
			end
			lru[index] <= 1'b0;
		end else begin
			if (install) begin
				valid[install_way][index] <= 1'b1;
				dirty[install_way][index] <= 1'b0;
				tags[install_way][index] <= tag;
				lru[index] <= ~install_way;
			end else if (hit) begin
				lru[index_q] <= ~hit_way;
			end
			if (mark_dirty) begin
				dirty[hit_way][index] <= 1'b1;
			end
		end
	end

	// registered read, install is forwarded so RELOOK sees the new line
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_valid <= '0;
		end else begin
			for (int w = 0; w < dcache_pkg::WAYS; w++) begin
				if (install && install_way == dcache_pkg::way_t'(w)) begin
					rd_valid[w] <= 1'b1;
				end else begin
					rd_valid[w] <= !init_busy && valid[w][index];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		index_q <= index;
		tag_q <= tag;
		rd_lru <= install ? ~install_way : lru[index];
		for (int w = 0; w < dcache_pkg::WAYS; w++) begin
			if (install && install_way == dcache_pkg::way_t'(w)) begin
				rd_tag[w] <= tag;
				rd_dirty[w] <= 1'b0;
			end else begin
				rd_tag[w] <= tags[w][index];
				rd_dirty[w] <= dirty[w][index];
			end
		end
	end

	always_comb begin
		for (int w = 0; w < dcache_pkg::WAYS; w++) begin
			hit_vec[w] = rd_valid[w] && (rd_tag[w] == tag_q);
		end
	end

	assign hit = |hit_vec;
	assign hit_way = hit_vec[1];

	// invalid way first, then lru
	always_comb begin
		if (!rd_valid[0]) begin
			victim_way = 1'b0;
		end else if (!rd_valid[1]) begin
			victim_way = 1'b1;
		end else begin
			victim_way = rd_lru;
		end
	end

	assign victim_dirty = rd_valid[victim_way] && rd_dirty[victim_way];
	assign victim_tag = rd_tag[victim_way];

	a_one_way_hit: assert property (@(posedge clk) disable iff (!rst_n)
		!(hit_vec[0] && hit_vec[1]));

endmodule

// File: source/dcache_data_store.sv
`timescale 1ns/1ns

module dcache_data_store (
	input  logic               clk,
	input  logic               wr_en,
	input  dcache_pkg::way_t   wr_way,
	input  dcache_pkg::index_t index,
	input  dcache_pkg::woff_t  wr_off,
	input  dcache_pkg::word_t  wr_data,
	input  dcache_pkg::wmask_t wr_mask,
	input  logic               fill_en,
	input  dcache_pkg::way_t   fill_way,
	input  dcache_pkg::woff_t  fill_off,
	input  dcache_pkg::word_t  fill_data,
	input  dcache_pkg::way_t   rd_way,
	input  dcache_pkg::woff_t  rd_off,
	output dcache_pkg::word_t  rd_data
);

	// one word per {index, offset} in each way
	dcache_pkg::word_t lines [dcache_pkg::WAYS][dcache_pkg::SETS*dcache_pkg::WORDS_PER_LINE];

	always_ff @(posedge clk) begin
		// cpu store, byte merged
		if (wr_en) begin
			for (int b = 0; b < dcache_pkg::WORD_W/8; b++) begin
				if (wr_mask[b]) begin
					lines[wr_way][{index, wr_off}][b*8 +: 8] <= wr_data[b*8 +: 8];
				end
			end
		end
		// refill beat
		if (fill_en) begin
			lines[fill_way][{index, fill_off}] <= fill_data;
		end
	end

	always_ff @(posedge clk) begin
		rd_data <= lines[rd_way][{index, rd_off}];
	end

	a_wr_fill_excl: assert property (@(posedge clk)
		!(wr_en === 1'b1 && fill_en === 1'b1));

endmodule

// File: source/dcache_line_xfer.sv
`timescale 1ns/1ns

module dcache_line_xfer (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start_wb,
	input  logic                 start_fill,
	input  dcache_pkg::way_t     way,
	input  dcache_pkg::index_t   index,
	input  dcache_pkg::tag_t     tag,
	output logic                 done,
	output dcache_pkg::woff_t    rd_off,
	input  dcache_pkg::word_t    rd_data,
	output logic                 fill_en,
	output dcache_pkg::woff_t    fill_off,
	output dcache_pkg::word_t    fill_data,
	output logic                 mem_valid,
	output dcache_pkg::mem_req_t mem_req,
	input  logic                 mem_ready,
	input  dcache_pkg::word_t    mem_rdata
);

	logic busy;
	logic is_wb;
	// one cycle to read the next word before a write beat
	logic prefetch;
	logic done_q;
	dcache_pkg::woff_t beat;
	logic beat_ack;
	logic last_beat;

	assign beat_ack = mem_valid && mem_ready;
	assign last_beat = (beat == dcache_pkg::woff_t'(dcache_pkg::WORDS_PER_LINE - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			is_wb <= 1'b0;
			prefetch <= 1'b0;
			mem_valid <= 1'b0;
			done_q <= 1'b0;
			beat <= '0;
		end else begin
			done_q <= 1'b0;
			if (!busy) begin
				if (start_wb || start_fill) begin
					busy <= 1'b1;
					is_wb <= start_wb;
					beat <= '0;
					prefetch <= start_wb;
					mem_valid <= start_fill;
				end
			end else if (prefetch) begin
				prefetch <= 1'b0;
				mem_valid <= 1'b1;
			end else if (beat_ack) begin
				if (last_beat) begin
					busy <= 1'b0;
					done_q <= 1'b1;
					mem_valid <= 1'b0;
				end else begin
					beat <= beat + 1'b1;
					prefetch <= is_wb;
					// refill can ask for the next word right away
					mem_valid <= !is_wb;
				end
			end
		end
	end

	always_comb begin
		mem_req.addr = {tag, index, beat, {dcache_pkg::BYTE_OFF_W{1'b0}}};
		mem_req.write = is_wb;
		mem_req.wdata = rd_data;
	end

	// write-back reads the word for the current beat
	assign rd_off = beat;

	assign fill_en = busy && !is_wb && beat_ack;
	assign fill_off = beat;
	assign fill_data = mem_rdata;

	assign done = done_q;

	a_valid_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(mem_valid) |-> busy);

	// controller must hold the target way for the whole burst
	a_way_stable: assert property (@(posedge clk) disable iff (!rst_n)
		busy |-> $stable(way));

endmodule

// File: source/dcache_top.sv
`timescale 1ns/1ns

module dcache_top (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 cpu_valid,
	input  dcache_pkg::cpu_req_t cpu_req,
	output logic                 cpu_ready,
	output dcache_pkg::word_t    cpu_rdata,
	output logic                 mem_valid,
	output dcache_pkg::mem_req_t mem_req,
	input  logic                 mem_ready,
	input  dcache_pkg::word_t    mem_rdata
);

	dcache_pkg::index_t lk_index;
	dcache_pkg::tag_t lk_tag;
	logic hit;
	dcache_pkg::way_t hit_way;
	dcache_pkg::way_t victim_way;
	logic victim_dirty;
	dcache_pkg::tag_t victim_tag;
	logic install;
	dcache_pkg::way_t install_way;
	logic mark_dirty;
	logic init_busy;
	logic wr_en;
	dcache_pkg::way_t wr_way;
	dcache_pkg::woff_t wr_off;
	dcache_pkg::word_t wr_data;
	dcache_pkg::wmask_t wr_mask;
	dcache_pkg::way_t ctrl_rd_way;
	dcache_pkg::woff_t ctrl_rd_off;
	dcache_pkg::woff_t xfer_rd_off;
	dcache_pkg::way_t rd_way;
	dcache_pkg::woff_t rd_off;
	dcache_pkg::word_t rd_data;
	logic start_wb;
	logic start_fill;
	dcache_pkg::way_t xfer_way;
	dcache_pkg::tag_t xfer_tag;
	logic xfer_done;
	logic fill_en;
	dcache_pkg::woff_t fill_off;
	dcache_pkg::word_t fill_data;
	logic wb_active;

	// engine owns the read port during a write-back
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_active <= 1'b0;
		end else if (start_wb) begin
			wb_active <= 1'b1;
		end else if (xfer_done) begin
			wb_active <= 1'b0;
		end
	end

	assign rd_way = wb_active ? xfer_way : ctrl_rd_way;
	assign rd_off = wb_active ? xfer_rd_off : ctrl_rd_off;
	assign cpu_rdata = rd_data;

	dcache_ctrl u_ctrl (
		.clk(clk), .rst_n(rst_n),
		.cpu_valid(cpu_valid), .cpu_req(cpu_req), .cpu_ready(cpu_ready),
		.lk_index(lk_index), .lk_tag(lk_tag),
		.hit(hit), .hit_way(hit_way),
		.victim_way(victim_way), .victim_dirty(victim_dirty), .victim_tag(victim_tag),
		.install(install), .install_way(install_way), .mark_dirty(mark_dirty),
		.wr_en(wr_en), .wr_way(wr_way), .wr_off(wr_off),
		.wr_data(wr_data), .wr_mask(wr_mask),
		.rd_way(ctrl_rd_way), .rd_off(ctrl_rd_off),
		.start_wb(start_wb), .start_fill(start_fill),
		.xfer_way(xfer_way), .xfer_tag(xfer_tag), .xfer_done(xfer_done),
		.init_busy(init_busy)
	);

	dcache_tag_store u_tag_store (
		.clk(clk), .rst_n(rst_n),
		.index(lk_index), .tag(lk_tag), .init_busy(init_busy),
		.install(install), .install_way(install_way), .mark_dirty(mark_dirty),
		.hit(hit), .hit_way(hit_way),
		.victim_way(victim_way), .victim_dirty(victim_dirty), .victim_tag(victim_tag)
	);

	dcache_data_store u_data_store (
		.clk(clk),
		.wr_en(wr_en), .wr_way(wr_way), .index(lk_index), .wr_off(wr_off),
		.wr_data(wr_data), .wr_mask(wr_mask),
		.fill_en(fill_en), .fill_way(xfer_way), .fill_off(fill_off), .fill_data(fill_data),
		.rd_way(rd_way), .rd_off(rd_off), .rd_data(rd_data)
	);

	dcache_line_xfer u_line_xfer (
		.clk(clk), .rst_n(rst_n),
		.start_wb(start_wb), .start_fill(start_fill),
		.way(xfer_way), .index(lk_index), .tag(xfer_tag), .done(xfer_done),
		.rd_off(xfer_rd_off), .rd_data(rd_data),
		.fill_en(fill_en), .fill_off(fill_off), .fill_data(fill_data),
		.mem_valid(mem_valid), .mem_req(mem_req),
		.mem_ready(mem_ready), .mem_rdata(mem_rdata)
	);

endmodule

// File: verif/dcache_mem_model.sv
`timescale 1ns/1ns

module dcache_mem_model (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [3:0]           ready_delay,
	input  logic                 mem_valid,
	input  dcache_pkg::mem_req_t mem_req,
	output logic                 mem_ready,
	output dcache_pkg::word_t    mem_rdata
);

	// 32 KB window, one entry per 64-bit word
	localparam int MEM_AW = 12;

	dcache_pkg::word_t mem [2**MEM_AW];
	logic [3:0] wait_cnt;
	logic [MEM_AW-1:0] waddr;

	assign waddr = mem_req.addr[dcache_pkg::BYTE_OFF_W +: MEM_AW];

	always @(posedge clk) begin
		if (!rst_n) begin
			mem_ready <= 1'b0;
			mem_rdata <= '0;
			wait_cnt <= '0;
		end else begin
			mem_ready <= 1'b0;
			// one answer per beat, the next request shows up a cycle later
			if (mem_valid && !mem_ready) begin
				if (wait_cnt >= ready_delay) begin
					mem_ready <= 1'b1;
					wait_cnt <= '0;
					if (mem_req.write) begin
						mem[waddr] <= mem_req.wdata;
					end else begin
						mem_rdata <= mem[waddr];
					end
				end else begin
					wait_cnt <= wait_cnt + 1'b1;
				end
			end
		end
	end

endmodule

// File: verif/dcache_tb.sv
`timescale 1ns/1ns

module dcache_tb;

	localparam int RESET_CYCLES = 16;
	localparam int DIRECTED_ACCESSES = 18;
	localparam int RANDOM_ACCESSES = 200;
	// worst miss is a dirty write-back plus a refill at the longest ready delay
	localparam int MISS_BOUND = 80;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + dcache_pkg::SETS
		+ (DIRECTED_ACCESSES + RANDOM_ACCESSES) * MISS_BOUND;
	localparam int SHADOW_WORDS = 4096;

	logic clk;
	logic rst_n;
	logic cpu_valid;
	dcache_pkg::cpu_req_t cpu_req;
	logic cpu_ready;
	dcache_pkg::word_t cpu_rdata;
	logic mem_valid;
	dcache_pkg::mem_req_t mem_req;
	logic mem_ready;
	dcache_pkg::word_t mem_rdata;
	logic [3:0] ready_delay;

	dcache_pkg::word_t shadow [SHADOW_WORDS];
	dcache_pkg::addr_t beat_addr [$];
	logic beat_write [$];
	dcache_pkg::word_t beat_data [$];
	int mem_busy_cycles = 0;
	int errors = 0;
	int accesses = 0;
	int total_beats = 0;
	int cycle_cnt = 0;
	logic [31:0] lcg_state;

	dcache_top dcache_top_i (
		.clk(clk), .rst_n(rst_n),
		.cpu_valid(cpu_valid), .cpu_req(cpu_req), .cpu_ready(cpu_ready),
		.cpu_rdata(cpu_rdata),
		.mem_valid(mem_valid), .mem_req(mem_req),
		.mem_ready(mem_ready), .mem_rdata(mem_rdata)
	);

	dcache_mem_model mem_model_i (
		.clk(clk), .rst_n(rst_n), .ready_delay(ready_delay),
		.mem_valid(mem_valid), .mem_req(mem_req),
		.mem_ready(mem_ready), .mem_rdata(mem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > TIMEOUT_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// records every memory beat of the current access
	always @(posedge clk) begin
		if (rst_n && mem_valid) begin
			mem_busy_cycles = mem_busy_cycles + 1;
		end
		if (rst_n && mem_valid && mem_ready) begin
			beat_addr.push_back(mem_req.addr);
			beat_write.push_back(mem_req.write);
			beat_data.push_back(mem_req.write ? mem_req.wdata : mem_rdata);
			total_beats = total_beats + 1;
		end
	end

	function automatic dcache_pkg::addr_t make_addr(int tag, int index, int woff);
		return {dcache_pkg::tag_t'(tag), dcache_pkg::index_t'(index),
			dcache_pkg::woff_t'(woff), 3'b000};
	endfunction

	function automatic int word_index(dcache_pkg::addr_t a);
		return int'(a[14:3]);
	endfunction

	// initial memory contents, a function of the full byte address
	function automatic dcache_pkg::word_t fill_word(int idx);
		logic [31:0] a;
		a = 32'(idx) << 3;
		return {a ^ 32'hc3a5_0f1e, a * 32'h9e37_79b9 + 32'h0000_0001};
	endfunction

	function automatic dcache_pkg::word_t merge_bytes(dcache_pkg::word_t old,
		dcache_pkg::word_t data, dcache_pkg::wmask_t mask);
		dcache_pkg::word_t res;
		res = old;
		for (int b = 0; b < 8; b++) begin
			if (mask[b]) begin
				res[b*8 +: 8] = data[b*8 +: 8];
			end
		end
		return res;
	endfunction

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic report_mismatch(input string test, input string what,
		input logic [63:0] expected, input logic [63:0] actual);
		$display("Error: %s %s expected %h actual %h", test, what, expected, actual);
		errors++;
	endtask

	// latency counts from the first cycle of cpu_valid to the ready cycle
	task automatic cpu_access(input dcache_pkg::addr_t addr, input logic is_write,
		input dcache_pkg::word_t wdata, input dcache_pkg::wmask_t wmask,
		output dcache_pkg::word_t rdata, output int latency);
		int waited;
		@(posedge clk);
		cpu_valid <= 1'b1;
		cpu_req.addr <= addr;
		cpu_req.write <= is_write;
		cpu_req.wdata <= wdata;
		cpu_req.wmask <= wmask;
		mem_busy_cycles = 0;
		beat_addr.delete();
		beat_write.delete();
		beat_data.delete();
		@(posedge clk);
		waited = 1;
		while (!cpu_ready) begin
			@(posedge clk);
			waited++;
		end
		rdata = cpu_rdata;
		latency = waited - 1;
		cpu_valid <= 1'b0;
		accesses++;
	endtask

	task automatic write_word(input string test, input dcache_pkg::addr_t addr,
		input dcache_pkg::word_t data, input dcache_pkg::wmask_t mask);
		dcache_pkg::word_t rdata;
		int latency;
		cpu_access(addr, 1'b1, data, mask, rdata, latency);
		shadow[word_index(addr)] = merge_bytes(shadow[word_index(addr)], data, mask);
	endtask

	task automatic read_word(input string test, input dcache_pkg::addr_t addr,
		output int latency);
		dcache_pkg::word_t rdata;
		dcache_pkg::word_t expected;
		cpu_access(addr, 1'b0, '0, '0, rdata, latency);
		expected = shadow[word_index(addr)];
		if (rdata !== expected) begin
			report_mismatch(test, $sformatf("read data at %h", addr), expected, rdata);
		end
	endtask

	// four beats of one line starting at queue position first
	task automatic check_line_beats(input string test, input int first,
		input logic is_write, input int tag, input int index);
		dcache_pkg::addr_t exp_addr;
		if (beat_addr.size() < first + 4) begin
			report_mismatch(test, "beats recorded", first + 4, beat_addr.size());
			return;
		end
		for (int k = 0; k < 4; k++) begin
			exp_addr = make_addr(tag, index, k);
			if (beat_write[first+k] !== is_write) begin
				report_mismatch(test, $sformatf("beat %0d direction", first + k),
					is_write, beat_write[first+k]);
			end
			if (beat_addr[first+k] !== exp_addr) begin
				report_mismatch(test, $sformatf("beat %0d address", first + k),
					exp_addr, beat_addr[first+k]);
			end
			if (is_write && beat_data[first+k] !== shadow[word_index(exp_addr)]) begin
				report_mismatch(test, $sformatf("beat %0d write data", first + k),
					shadow[word_index(exp_addr)], beat_data[first+k]);
			end
		end
	endtask

	task automatic check_no_traffic(input string test);
		if (mem_busy_cycles != 0) begin
			report_mismatch(test, "cycles with mem_valid high", 0, mem_busy_cycles);
		end
	endtask

	task automatic read_miss_refill();
		int latency;
		read_word("read_miss_refill", make_addr(1, 3, 2), latency);
		if (beat_addr.size() != 4) begin
			report_mismatch("read_miss_refill", "beat count", 4, beat_addr.size());
		end
		check_line_beats("read_miss_refill", 0, 1'b0, 1, 3);
	endtask

	task automatic read_hit();
		int latency;
		for (int w = 0; w < 4; w++) begin
			if (w != 2) begin
				read_word("read_hit", make_addr(1, 3, w), latency);
				check_no_traffic("read_hit");
				if (latency != 2) begin
					report_mismatch("read_hit", "ready latency", 2, latency);
				end
			end
		end
	endtask

	task automatic masked_write();
		dcache_pkg::addr_t a;
		int latency;
		a = make_addr(1, 3, 1);
		write_word("masked_write", a, 64'h0123_4567_89ab_cdef, 8'b0011_1100);
		check_no_traffic("masked_write");
		read_word("masked_write", a, latency);
		check_no_traffic("masked_write");
	endtask

	task automatic dirty_eviction();
		int latency;
		// tag 2 becomes dirty, tag 3 fills the other way, tag 4 evicts tag 2
		write_word("dirty_eviction", make_addr(2, 9, 0), 64'hfeed_face_dead_beef, 8'hf0);
		write_word("dirty_eviction", make_addr(2, 9, 3), 64'h1111_2222_3333_4444, 8'h0f);
		read_word("dirty_eviction", make_addr(3, 9, 1), latency);
		read_word("dirty_eviction", make_addr(4, 9, 2), latency);
		if (beat_addr.size() != 8) begin
			report_mismatch("dirty_eviction", "beat count", 8, beat_addr.size());
		end
		check_line_beats("dirty_eviction", 0, 1'b1, 2, 9);
		check_line_beats("dirty_eviction", 4, 1'b0, 4, 9);
		read_word("dirty_eviction", make_addr(2, 9, 0), latency);
		check_line_beats("dirty_eviction", 0, 1'b0, 2, 9);
	endtask

	task automatic lru_choice();
		int latency;
		// A is tag 6 and fills way 0, B is tag 5, C is tag 7
		read_word("lru_choice", make_addr(6, 17, 0), latency);
		read_word("lru_choice", make_addr(5, 17, 0), latency);
		read_word("lru_choice", make_addr(5, 17, 1), latency);
		read_word("lru_choice", make_addr(6, 17, 1), latency);
		read_word("lru_choice", make_addr(7, 17, 2), latency);
		read_word("lru_choice", make_addr(6, 17, 3), latency);
		check_no_traffic("lru_choice");
		read_word("lru_choice", make_addr(5, 17, 3), latency);
		if (beat_addr.size() != 4) begin
			report_mismatch("lru_choice", "beat count for evicted line", 4, beat_addr.size());
		end
	endtask

	task automatic random_traffic();
		dcache_pkg::addr_t a;
		dcache_pkg::word_t data;
		dcache_pkg::wmask_t mask;
		logic [31:0] r;
		int latency;
		for (int i = 0; i < RANDOM_ACCESSES; i++) begin
			r = lcg_next();
			// eight tags over three sets keeps evictions frequent
			a = make_addr(int'(r[31:29]), 40 + int'(r[28:26]) % 3, int'(r[25:24]));
			@(posedge clk);
			ready_delay <= 4'(r[23:22]);
			if (r[21]) begin
				data = {lcg_next(), lcg_next()};
				mask = 8'(lcg_next() >> 24);
				write_word("random_traffic", a, data, mask);
			end else begin
				read_word("random_traffic", a, latency);
			end
		end
	endtask

	initial begin
		lcg_state = 32'hcc11_d257;
		rst_n = 1'b0;
		cpu_valid = 1'b0;
		cpu_req = '0;
		ready_delay = 4'd1;
		for (int i = 0; i < SHADOW_WORDS; i++) begin
			shadow[i] = fill_word(i);
			mem_model_i.mem[i] = fill_word(i);
		end
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;

		read_miss_refill();
		read_hit();
		masked_write();
		dirty_eviction();
		lru_choice();
		random_traffic();

		$display("accesses %0d, memory beats %0d, errors %0d", accesses, total_beats, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: compile.f
source/dcache_pkg.sv
source/dcache_ctrl.sv
source/dcache_tag_store.sv
source/dcache_data_store.sv
source/dcache_line_xfer.sv
source/dcache_top.sv
verif/dcache_mem_model.sv
verif/dcache_tb.sv
